// File: verilog/noc_cfg_pkg.sv
package noc_cfg_pkg;

  // ------------------------------------------------------------------------
  // Router geometry
  // ------------------------------------------------------------------------

  // A mesh router has as many outputs as inputs, so one count serves both
  localparam int NUM_PORTS = 5;

  // Width of a port index, as held by the arbiter priority pointers
  localparam int PORT_W = $clog2(NUM_PORTS);

  // Port numbering, shared by route computation and the top level
  // North is the direction of increasing Y and east of increasing X
  localparam int PORT_LOCAL = 0;
  localparam int PORT_NORTH = 1;
  localparam int PORT_EAST  = 2;
  localparam int PORT_SOUTH = 3;
  localparam int PORT_WEST  = 4;

  // Flit queue entries per input, with pointer and occupancy widths
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // One bit per port, bit index equals port index
  typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

// File: verilog/noc_flit_pkg.sv
package noc_flit_pkg;

  // A flit is packed as destination X, then destination Y, then payload,
  // with destination X in the top bits
  localparam int COORD_W   = 3;
  localparam int PAYLOAD_W = 16;
  localparam int FLIT_W    = 2 * COORD_W + PAYLOAD_W;

  typedef logic [COORD_W-1:0]   coord_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;
  typedef logic [FLIT_W-1:0]    flit_t;

  // Field extraction for the routing logic
  function automatic coord_t flit_dst_x(flit_t f);
    return f[FLIT_W-1 -: COORD_W];
  endfunction

  function automatic coord_t flit_dst_y(flit_t f);
    return f[PAYLOAD_W +: COORD_W];
  endfunction

endpackage

// File: verilog/noc_switch_if.sv
interface noc_switch_if
  import noc_cfg_pkg::*, noc_flit_pkg::*;
;

  // Every array is indexed by input port, except grant
  // Head flit of each input queue, meaningful while head_valid is set
  flit_t     head [NUM_PORTS];

  // Set for each input whose queue is non-empty
  port_vec_t head_valid;

  // Each input requests one output, one-hot, or nothing at all
  port_vec_t req [NUM_PORTS];

  // Indexed by output port, names the input chosen for that output
  port_vec_t grant [NUM_PORTS];

  // Input units present their heads and requests and watch for grants
  modport unit (output head, output head_valid, output req, input grant);

  // The switch control turns requests into grants
  modport ctrl (input req, output grant);

  // The crossbar steers granted heads to the outputs
  modport xbar (input head, input grant);

endinterface

// File: verilog/noc_input_unit.sv
module noc_input_unit
  import noc_cfg_pkg::*, noc_flit_pkg::*;
#(
  parameter int X_POS   = 0,
  parameter int Y_POS   = 0,
  parameter int PORT_ID = PORT_LOCAL
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  flit_t      i_flit,
  input  logic       i_valid,
  output logic       o_en,
  noc_switch_if.unit sw
);

  flit_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  push;
  logic                  pop;
  flit_t                 head;
  coord_t                dst_x;
  coord_t                dst_y;
  port_vec_t             route;

  // Pointers wrap explicitly so that any queue depth works
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(logic [FIFO_PTR_W-1:0] p);
    if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ------------------------------------------------------------------------
  // Flit queue
  // ------------------------------------------------------------------------

  // Upstream may send whenever there is room
  assign o_en = (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign push = i_valid & o_en;

  // The head leaves when any output grants this input
  always_comb begin
    pop = 1'b0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      pop = pop | sw.grant[o][PORT_ID];
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_flit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // A push and a pop together leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // XY route of the head flit
  // ------------------------------------------------------------------------

  assign head  = mem[rd_ptr];
  assign dst_x = flit_dst_x(head);
  assign dst_y = flit_dst_y(head);

  // Resolve X first, then Y, then deliver locally
  always_comb begin
    route = '0;
    if (dst_x > coord_t'(X_POS)) begin
      route[PORT_EAST] = 1'b1;
    end else if (dst_x < coord_t'(X_POS)) begin
      route[PORT_WEST] = 1'b1;
    end else if (dst_y > coord_t'(Y_POS)) begin
      route[PORT_NORTH] = 1'b1;
    end else if (dst_y < coord_t'(Y_POS)) begin
      route[PORT_SOUTH] = 1'b1;
    end else begin
      route[PORT_LOCAL] = 1'b1;
    end
  end

  assign sw.head[PORT_ID]       = head;
  assign sw.head_valid[PORT_ID] = (count != '0);
  // An empty queue requests nothing, whatever its stale head holds
  assign sw.req[PORT_ID]        = sw.head_valid[PORT_ID] ? route : '0;

endmodule

// File: verilog/noc_rr_arbiter.sv
module noc_rr_arbiter
  import noc_cfg_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  port_vec_t i_req,
  output port_vec_t o_grant
);

  logic [PORT_W-1:0] ptr;
  logic [PORT_W-1:0] winner;
  logic              found;
  int                cand;

  // Search starts at the pointer and wraps past the last port
  // The first requester met in that order wins
  always_comb begin
    o_grant = '0;
    found   = 1'b0;
    winner  = ptr;
    cand    = 0;
    for (int off = 0; off < NUM_PORTS; off++) begin
      cand = int'(ptr) + off;
      if (cand >= NUM_PORTS) begin
        cand = cand - NUM_PORTS;
      end
      if (!found && i_req[cand]) begin
        found  = 1'b1;
        winner = PORT_W'(cand);
      end
    end
    if (found) begin
      o_grant[winner] = 1'b1;
    end
  end

  // Priority moves just past the winner, so it is served last next time
  // An idle cycle leaves the pointer where it was
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr <= '0;
    end else if (found) begin
      if (winner == PORT_W'(NUM_PORTS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= winner + 1'b1;
      end
    end
  end

endmodule

// File: verilog/noc_switch_control.sv
module noc_switch_control
  import noc_cfg_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  port_vec_t  i_en,
  noc_switch_if.ctrl sw
);

  // Requests regrouped by output, one bit per requesting input
  port_vec_t out_req [NUM_PORTS];

  // ------------------------------------------------------------------------
  // Request transpose and output gating
  // ------------------------------------------------------------------------

  // Each input raises at most one request, so arbitration is needed only
  // at the outputs
  // A disabled output sees no requests at all and grants nothing
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        out_req[o][i] = sw.req[i][o] & i_en[o];
      end
    end
  end

  // ------------------------------------------------------------------------
  // One round-robin arbiter per output
  // ------------------------------------------------------------------------

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out_arb
    noc_rr_arbiter u_arb (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_req   (out_req[o]),
      .o_grant (sw.grant[o])
    );
  end

endmodule

// File: verilog/noc_crossbar.sv
module noc_crossbar
  import noc_cfg_pkg::*, noc_flit_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  noc_switch_if.xbar sw,
  output flit_t      o_flit [NUM_PORTS],
  output port_vec_t  o_valid
);

  flit_t     sel_flit [NUM_PORTS];
  port_vec_t any_grant;

  // ------------------------------------------------------------------------
  // Selection
  // ------------------------------------------------------------------------

  // Grants are one-hot, so an AND-OR tree picks the granted head
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      sel_flit[o]  = '0;
      any_grant[o] = |sw.grant[o];
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (sw.grant[o][i]) begin
          sel_flit[o] = sel_flit[o] | sw.head[i];
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------------------

  // A grant in one cycle shows as a valid output in the next
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= '0;
    end else begin
      o_valid <= any_grant;
    end
  end

  // The output flit holds its last value while nothing is granted
  always_ff @(posedge i_clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (any_grant[o]) begin
        o_flit[o] <= sel_flit[o];
      end
    end
  end

endmodule

// File: verilog/noc_router.sv
module noc_router
  import noc_cfg_pkg::*, noc_flit_pkg::*;
#(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic      i_clk,
  input  logic      i_rst,

  // Upstream side, one flit and valid per input, enable back per input
  input  flit_t     i_flit [NUM_PORTS],
  input  port_vec_t i_valid,
  output port_vec_t o_en,

  // Downstream side, enable in per output, flit and valid out per output
  input  port_vec_t i_en,
  output flit_t     o_flit [NUM_PORTS],
  output port_vec_t o_valid
);

  // Heads, requests and grants shared by the three blocks
  noc_switch_if sw_if ();

  // ------------------------------------------------------------------------
  // Input units, one per port, each with its own queue and route logic
  // ------------------------------------------------------------------------

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
    noc_input_unit #(
      .X_POS   (X_POS),
      .Y_POS   (Y_POS),
      .PORT_ID (p)
    ) u_in (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_flit  (i_flit[p]),
      .i_valid (i_valid[p]),
      .o_en    (o_en[p]),
      .sw      (sw_if.unit)
    );
  end

  // Requests become grants in the same cycle
  noc_switch_control u_ctrl (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_en  (i_en),
    .sw    (sw_if.ctrl)
  );

  // Granted heads are registered onto the outputs
  noc_crossbar u_xbar (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .sw      (sw_if.xbar),
    .o_flit  (o_flit),
    .o_valid (o_valid)
  );

endmodule

// File: bench/noc_router_assertions.sv
module noc_router_assertions
  import noc_cfg_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  port_vec_t i_valid,
  input  port_vec_t i_up_en,
  input  port_vec_t i_en,
  input  port_vec_t i_out_valid,
  input  port_vec_t i_grant [NUM_PORTS]
);

  // Read by the testbench to fold assertion failures into its verdict
  int        fail_count = 0;
  logic      seen_accept;
  int        occ [NUM_PORTS];
  port_vec_t pop;

  // ------------------------------------------------------------------------
  // Reference occupancy, counted from accepts and grants
  // ------------------------------------------------------------------------

  // An input leaves its queue when any output grants it
  always_comb begin
    pop = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      pop = pop | i_grant[o];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_accept <= 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        occ[p] <= 0;
      end
    end else begin
      if ((i_valid & i_up_en) != '0) begin
        seen_accept <= 1'b1;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        occ[p] <= occ[p] + int'(i_valid[p] & i_up_en[p]) - int'(pop[p]);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Properties
  // ------------------------------------------------------------------------

  // Outputs stay quiet until something has entered the router
  assert property (@(posedge i_clk) disable iff (i_rst)
    !seen_accept |-> (i_out_valid == '0))
    else begin
      fail_count++;
      $error("An output became valid before any flit was accepted");
    end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // A flit only leaves through an output that was enabled one cycle before
    assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_valid[p] |-> $past(i_en[p]))
      else begin
        fail_count++;
        $error("Output %0d was valid although its enable was low", p);
      end

    // Upstream is held off only when the queue really holds FIFO_DEPTH flits
    assert property (@(posedge i_clk) disable iff (i_rst)
      !i_up_en[p] |-> (occ[p] == FIFO_DEPTH))
      else begin
        fail_count++;
        $error("Input %0d refused flits with only %0d queued", p, occ[p]);
      end
  end

endmodule

bind noc_router noc_router_assertions u_assert (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_valid     (i_valid),
  .i_up_en     (o_en),
  .i_en        (i_en),
  .i_out_valid (o_valid),
  .i_grant     (sw_if.grant)
);

// File: bench/noc_router_tb.sv
module noc_router_tb
  import noc_cfg_pkg::*, noc_flit_pkg::*;
;

  localparam int X_POS      = 2;
  localparam int Y_POS      = 2;
  localparam int SRC_W      = 3;
  localparam int MAX_CYCLES = 600;

  logic      i_clk;
  logic      i_rst;
  flit_t     i_flit [NUM_PORTS];
  port_vec_t i_valid;
  port_vec_t o_en;
  port_vec_t i_en;
  flit_t     o_flit [NUM_PORTS];
  port_vec_t o_valid;

  // Expected flits by output and source input, oldest first
  flit_t exp_q [NUM_PORTS][NUM_PORTS][$];
  int    due [NUM_PORTS];
  int    seed = 13293;
  int    cyc = 0;
  int    pending = 0;
  int    test_errs = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    assert_base = 0;
  int    last_src = -1;
  bit    check_lat = 1'b0;
  bit    check_fair = 1'b0;
  string test_name = "reset";

  noc_router #(
    .X_POS (X_POS),
    .Y_POS (Y_POS)
  ) dut0 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_flit  (i_flit),
    .i_valid (i_valid),
    .o_en    (o_en),
    .i_en    (i_en),
    .o_flit  (o_flit),
    .o_valid (o_valid)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Hard stop well beyond the summed length of all tests
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, test %s never finished", cyc, test_name);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // XY rule: east or west until X matches, then north or south, then local
  function automatic int xy_port(flit_t f);
    int dx;
    int dy;
    dx = int'(f[FLIT_W-1 -: COORD_W]);
    dy = int'(f[PAYLOAD_W +: COORD_W]);
    if (dx > X_POS) return PORT_EAST;
    if (dx < X_POS) return PORT_WEST;
    if (dy > Y_POS) return PORT_NORTH;
    if (dy < Y_POS) return PORT_SOUTH;
    return PORT_LOCAL;
  endfunction

  // ------------------------------------------------------------------------
  // Scoreboard, sampled mid-cycle where every signal is settled
  // ------------------------------------------------------------------------

  task automatic check_output(int o);
    flit_t got;
    flit_t want;
    int    src;
    got = o_flit[o];
    // The top payload bits carry the source input
    src = int'(got[PAYLOAD_W-1 -: SRC_W]);
    if (src >= NUM_PORTS || exp_q[o][src].size() == 0) begin
      $display("Unexpected flit %h left output %0d in test %s", got, o, test_name);
      test_errs++;
    end else begin
      want = exp_q[o][src].pop_front();
      pending--;
      assert (got == want) else begin
        $display("Fail %s: expected %h, actual %h", test_name, want, got);
        test_errs++;
      end
      if (check_lat) begin
        assert (cyc == due[o]) else begin
          $display("Fail %s: expected cycle %0d, actual %0d", test_name, due[o], cyc);
          test_errs++;
        end
      end
      if (check_fair && last_src >= 0) begin
        assert (src == (last_src + 1) % NUM_PORTS) else begin
          $display("Fail %s: expected source %0d, actual source %0d", test_name,
                   (last_src + 1) % NUM_PORTS, src);
          test_errs++;
        end
      end
      last_src = src;
    end
  endtask

  always @(negedge i_clk) begin : monitor
    int dst;
    if (!i_rst) begin
      // A flit seen here with room in its queue is taken at the next edge
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (i_valid[p] && o_en[p]) begin
          dst = xy_port(i_flit[p]);
          exp_q[dst][p].push_back(i_flit[p]);
          due[dst] = cyc + 2;
          pending++;
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (o_valid[o]) begin
          check_output(o);
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------------

  task automatic offer(int p, coord_t x, coord_t y);
    payload_t pay;
    pay = payload_t'($random(seed));
    pay[PAYLOAD_W-1 -: SRC_W] = SRC_W'(p);
    i_flit[p]  <= {x, y, pay};
    i_valid[p] <= 1'b1;
  endtask

  task automatic send_one(int p, coord_t x, coord_t y);
    @(posedge i_clk);
    offer(p, x, y);
    @(posedge i_clk);
    i_valid[p] <= 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != 0) @(negedge i_clk);
    // A few idle cycles catch any stray flit
    repeat (3) @(negedge i_clk);
    // Hand over on a rising edge, clear of the monitor's sampling point
    @(posedge i_clk);
  endtask

  // Every input streams per_input flits back to back, holding each until taken
  // Random mode picks destinations and output enables at random
  task automatic run_traffic(int per_input, bit random_mode);
    int        left [NUM_PORTS];
    int        total;
    port_vec_t acc;
    port_vec_t en;
    coord_t    x;
    coord_t    y;
    total = per_input * NUM_PORTS;
    for (int p = 0; p < NUM_PORTS; p++) begin
      left[p] = per_input;
    end
    while (total != 0 || i_valid != '0) begin
      @(negedge i_clk);
      acc = i_valid & o_en;
      @(posedge i_clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (acc[p] || !i_valid[p]) begin
          if (left[p] > 0) begin
            x = random_mode ? coord_t'($unsigned($random(seed)) % 5) : coord_t'(X_POS);
            y = random_mode ? coord_t'($unsigned($random(seed)) % 5) : coord_t'(Y_POS);
            offer(p, x, y);
            left[p]--;
            total--;
          end else begin
            i_valid[p] <= 1'b0;
          end
        end
      end
      if (random_mode) begin
        // Each output is enabled three cycles out of four on average
        for (int o = 0; o < NUM_PORTS; o++) begin
          en[o] = (($random(seed) & 3) != 0);
        end
        i_en <= en;
      end
    end
    i_en <= '1;
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_errs   = 0;
    assert_base = dut0.u_assert.fail_count;
  endtask

  task automatic end_test();
    int asrt;
    asrt = dut0.u_assert.fail_count - assert_base;
    tests_run++;
    if (test_errs == 0 && asrt == 0) begin
      $display("Test %s: ok", test_name);
    end else begin
      $display("Test %s: %0d check errors, %0d assertion failures",
               test_name, test_errs, asrt);
      tests_failed++;
      errors += test_errs + asrt;
    end
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------

  initial begin
    i_rst   = 1'b1;
    i_valid = '0;
    i_en    = '1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      i_flit[p] = '0;
    end
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;

    // One flit to each of the five directions
    start_test("routing");
    send_one(PORT_LOCAL, coord_t'(X_POS), coord_t'(Y_POS));
    send_one(PORT_LOCAL, coord_t'(X_POS + 2), coord_t'(0));
    send_one(PORT_LOCAL, coord_t'(0), coord_t'(4));
    send_one(PORT_LOCAL, coord_t'(X_POS), coord_t'(Y_POS + 2));
    send_one(PORT_LOCAL, coord_t'(X_POS), coord_t'(0));
    wait_drain();
    end_test();

    start_test("latency");
    check_lat = 1'b1;
    send_one(PORT_NORTH, coord_t'(X_POS), coord_t'(Y_POS));
    wait_drain();
    check_lat = 1'b0;
    end_test();

    // East held off until the local queue is full
    start_test("backpressure");
    @(posedge i_clk);
    i_en[PORT_EAST] <= 1'b0;
    repeat (FIFO_DEPTH) send_one(PORT_LOCAL, coord_t'(X_POS + 1), coord_t'(Y_POS));
    repeat (2) @(negedge i_clk);
    assert (!o_en[PORT_LOCAL]) else begin
      $display("Local input still accepted flits with a full queue in test %s", test_name);
      test_errs++;
    end
    assert (pending == FIFO_DEPTH) else begin
      $display("Fail %s: expected %0d queued, actual %0d", test_name, FIFO_DEPTH, pending);
      test_errs++;
    end
    @(posedge i_clk);
    i_en[PORT_EAST] <= 1'b1;
    wait_drain();
    end_test();

    start_test("fairness");
    check_fair = 1'b1;
    last_src   = -1;
    run_traffic(8, 1'b0);
    wait_drain();
    check_fair = 1'b0;
    end_test();

    // Five inputs to five distinct outputs in the same cycle
    start_test("parallel");
    check_lat = 1'b1;
    @(posedge i_clk);
    offer(PORT_LOCAL, coord_t'(X_POS + 1), coord_t'(Y_POS));
    offer(PORT_NORTH, coord_t'(X_POS - 1), coord_t'(Y_POS));
    offer(PORT_EAST, coord_t'(X_POS), coord_t'(Y_POS + 1));
    offer(PORT_SOUTH, coord_t'(X_POS), coord_t'(Y_POS - 1));
    offer(PORT_WEST, coord_t'(X_POS), coord_t'(Y_POS));
    @(posedge i_clk);
    i_valid <= '0;
    wait_drain();
    check_lat = 1'b0;
    end_test();

    start_test("random");
    run_traffic(40, 1'b1);
    wait_drain();
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut0.u_assert.fail_count);
    if (tests_failed == 0 && errors == 0 && dut0.u_assert.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
verilog/noc_cfg_pkg.sv
verilog/noc_flit_pkg.sv
verilog/noc_switch_if.sv
verilog/noc_input_unit.sv
verilog/noc_rr_arbiter.sv
verilog/noc_switch_control.sv
verilog/noc_crossbar.sv
verilog/noc_router.sv
bench/noc_router_assertions.sv
bench/noc_router_tb.sv
